// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the load/store pipeline testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary -f src.f --top-module tb_lsu -Mdir "$BUILD_DIR" -o tb_lsu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_lsu" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Test FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

echo "Simulation passed"
exit 0

// ==== source/exe_stage.sv ====
// Execute stage
// Effective address generation for loads and stores.
module exe_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_req,
  output logic                      o_ack,
  input  lsu_pkg::insn_u            i_insn,
  input  lsu_pkg::xlen_t            i_rs1_val,
  input  lsu_pkg::xlen_t            i_rs2_val,
  output logic                      o_req,
  input  logic                      i_ack,
  output lsu_pkg::xlen_t            o_addr,
  output logic                      o_ren,
  output logic                      o_wen,
  output lsu_pkg::funct3_t          o_funct3,
  output lsu_pkg::xlen_t            o_wdata,
  output logic [lsu_pkg::REG_W-1:0] o_rd
);
  import lsu_pkg::*;

  logic        accept;
  logic        is_load;
  logic        is_store;
  logic [11:0] imm;
  xlen_t       imm_sext;

  // Free when empty or when the held entry leaves this cycle.
  assign o_ack  = !o_req || i_ack;
  assign accept = i_req && o_ack;

  assign is_load  = (i_insn.i.opcode == OPC_LOAD);
  assign is_store = (i_insn.i.opcode == OPC_STORE);

  // Store immediate is split around rs1/funct3.
  assign imm = is_store ? {i_insn.s.imm_hi, i_insn.s.imm_lo} : i_insn.i.imm;
  assign imm_sext = {{(XLEN-12){imm[11]}}, imm};

  always_ff @(posedge clk) begin
    if (rst) begin
      o_req <= 1'b0;
    end else if (accept) begin
      // Other opcodes are consumed here.
      o_req <= is_load || is_store;
    end else if (i_ack) begin
      o_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      o_addr   <= i_rs1_val + imm_sext;
      o_ren    <= is_load;
      o_wen    <= is_store;
      o_funct3 <= i_insn.i.funct3;
      o_wdata  <= i_rs2_val;
      o_rd     <= i_insn.i.rd;
    end
  end

endmodule

// ==== source/lsu_pkg.sv ====
// Load/store unit shared definitions
package lsu_pkg;

  // Data and address width.
  localparam int XLEN = 64;
  // Register index width.
  localparam int REG_W = 5;

  // Major opcodes.
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  typedef logic [2:0] funct3_t;
  typedef logic [XLEN-1:0] xlen_t;

  // Access size codes; stores use the first four only.
  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_D  = 3'b011;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;
  localparam funct3_t F3_WU = 3'b110;

  // I-type layout, used by loads.
  typedef struct packed {
    logic [11:0]      imm;
    logic [REG_W-1:0] rs1;
    funct3_t          funct3;
    logic [REG_W-1:0] rd;
    logic [6:0]       opcode;
  } insn_i_t;

  // S-type layout, used by stores.
  typedef struct packed {
    logic [6:0]       imm_hi;
    logic [REG_W-1:0] rs2;
    logic [REG_W-1:0] rs1;
    funct3_t          funct3;
    logic [4:0]       imm_lo;
    logic [6:0]       opcode;
  } insn_s_t;

  // One instruction word seen in either form.
  typedef union packed {
    insn_i_t i;
    insn_s_t s;
  } insn_u;

endpackage

// ==== source/lsu_top.sv ====
// Load/store pipeline top level
module lsu_top #(
  parameter int MEM_WORDS = 256
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_req,
  output logic                      o_ack,
  input  lsu_pkg::insn_u            i_insn,
  input  lsu_pkg::xlen_t            i_rs1_val,
  input  lsu_pkg::xlen_t            i_rs2_val,
  output logic                      o_wb_req,
  input  logic                      i_wb_ack,
  output logic [lsu_pkg::REG_W-1:0] o_wb_rd,
  output lsu_pkg::xlen_t            o_wb_data
);
  import lsu_pkg::*;

  // Execute to memory.
  logic             e_req;
  logic             e_ack;
  xlen_t            e_addr;
  logic             e_ren;
  logic             e_wen;
  funct3_t          e_funct3;
  xlen_t            e_wdata;
  logic [REG_W-1:0] e_rd;

  // Memory to writeback.
  logic             m_req;
  logic             m_ack;
  xlen_t            m_rdata;
  logic [REG_W-1:0] m_rd;

  exe_stage u_exe_stage (
    .clk       (clk),
    .rst       (rst),
    .i_req     (i_req),
    .o_ack     (o_ack),
    .i_insn    (i_insn),
    .i_rs1_val (i_rs1_val),
    .i_rs2_val (i_rs2_val),
    .o_req     (e_req),
    .i_ack     (e_ack),
    .o_addr    (e_addr),
    .o_ren     (e_ren),
    .o_wen     (e_wen),
    .o_funct3  (e_funct3),
    .o_wdata   (e_wdata),
    .o_rd      (e_rd)
  );

  mem_stage #(
    .MEM_WORDS (MEM_WORDS)
  ) u_mem_stage (
    .clk      (clk),
    .rst      (rst),
    .i_req    (e_req),
    .o_ack    (e_ack),
    .o_req    (m_req),
    .i_ack    (m_ack),
    .i_addr   (e_addr),
    .i_ren    (e_ren),
    .i_wen    (e_wen),
    .i_funct3 (e_funct3),
    .i_wdata  (e_wdata),
    .i_rd     (e_rd),
    .o_rdata  (m_rdata),
    .o_rd     (m_rd)
  );

  wb_stage u_wb_stage (
    .clk     (clk),
    .rst     (rst),
    .i_req   (m_req),
    .o_ack   (m_ack),
    .i_rdata (m_rdata),
    .i_rd    (m_rd),
    .o_req   (o_wb_req),
    .i_ack   (i_wb_ack),
    .o_data  (o_wb_data),
    .o_rd    (o_wb_rd)
  );

endmodule

// ==== source/mem_stage.sv ====
// Memory stage
module mem_stage #(
  parameter int MEM_WORDS = 256
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_req,
  output logic                      o_ack,
  output logic                      o_req,
  input  logic                      i_ack,
  input  lsu_pkg::xlen_t            i_addr,
  input  logic                      i_ren,
  input  logic                      i_wen,
  input  lsu_pkg::funct3_t          i_funct3,
  input  lsu_pkg::xlen_t            i_wdata,
  input  logic [lsu_pkg::REG_W-1:0] i_rd,
  output lsu_pkg::xlen_t            o_rdata,
  output logic [lsu_pkg::REG_W-1:0] o_rd
);
  import lsu_pkg::*;

  logic    accept;
  xlen_t   lat_addr;
  funct3_t lat_funct3;

  // Stores never occupy the stage, so only a pending load blocks.
  assign o_ack  = !o_req || i_ack;
  assign accept = i_req && o_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_req <= 1'b0;
    end else if (accept) begin
      o_req <= i_ren;
    end else if (i_ack) begin
      o_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      lat_addr   <= i_addr;
      lat_funct3 <= i_funct3;
      o_rd       <= i_rd;
    end
  end

  // Write goes in on the accepting edge.
  mem_unit #(
    .MEM_WORDS (MEM_WORDS)
  ) u_mem_unit (
    .clk       (clk),
    .rst       (rst),
    .i_we      (accept && i_wen),
    .i_waddr   (i_addr),
    .i_wfunct3 (i_funct3),
    .i_wdata   (i_wdata),
    .i_raddr   (lat_addr),
    .i_rfunct3 (lat_funct3),
    .o_rdata   (o_rdata)
  );

endmodule

// ==== source/mem_unit.sv ====
// Doubleword data memory
// Byte-lane store merge, load extraction and extension.
module mem_unit #(
  parameter int MEM_WORDS = 256
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_we,
  input  lsu_pkg::xlen_t   i_waddr,
  input  lsu_pkg::funct3_t i_wfunct3,
  input  lsu_pkg::xlen_t   i_wdata,
  input  lsu_pkg::xlen_t   i_raddr,
  input  lsu_pkg::funct3_t i_rfunct3,
  output lsu_pkg::xlen_t   o_rdata
);
  import lsu_pkg::*;

  // Word index wraps; MEM_WORDS is a power of two.
  localparam int IDX_W = $clog2(MEM_WORDS);

  xlen_t            mem [MEM_WORDS];
  logic [IDX_W-1:0] widx;
  logic [IDX_W-1:0] ridx;
  logic [7:0]       size_mask;
  logic [7:0]       lane_en;
  xlen_t            wdata_sh;
  xlen_t            rword;

  assign widx = i_waddr[IDX_W+2:3];
  assign ridx = i_raddr[IDX_W+2:3];

  always_comb begin
    case (i_wfunct3[1:0])
      2'b00:   size_mask = 8'h01;
      2'b01:   size_mask = 8'h03;
      2'b10:   size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  // Move the store bytes up to their lanes.
  assign lane_en  = size_mask << i_waddr[2:0];
  assign wdata_sh = i_wdata << {i_waddr[2:0], 3'b000};

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (i_we) begin
      for (int b = 0; b < 8; b++) begin
        if (lane_en[b]) begin
          mem[widx][b*8 +: 8] <= wdata_sh[b*8 +: 8];
        end
      end
    end
  end

  // Addressed bytes land in the low lanes.
  assign rword = mem[ridx] >> {i_raddr[2:0], 3'b000};

  always_comb begin
    case (i_rfunct3)
      F3_B:    o_rdata = {{(XLEN-8){rword[7]}}, rword[7:0]};
      F3_H:    o_rdata = {{(XLEN-16){rword[15]}}, rword[15:0]};
      F3_W:    o_rdata = {{(XLEN-32){rword[31]}}, rword[31:0]};
      F3_BU:   o_rdata = {{(XLEN-8){1'b0}}, rword[7:0]};
      F3_HU:   o_rdata = {{(XLEN-16){1'b0}}, rword[15:0]};
      F3_WU:   o_rdata = {{(XLEN-32){1'b0}}, rword[31:0]};
      default: o_rdata = rword;
    endcase
  end

endmodule

// ==== source/wb_stage.sv ====
// Writeback stage
module wb_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_req,
  output logic                      o_ack,
  input  lsu_pkg::xlen_t            i_rdata,
  input  logic [lsu_pkg::REG_W-1:0] i_rd,
  output logic                      o_req,
  input  logic                      i_ack,
  output lsu_pkg::xlen_t            o_data,
  output logic [lsu_pkg::REG_W-1:0] o_rd
);
  import lsu_pkg::*;

  logic accept;

  assign o_ack  = !o_req || i_ack;
  assign accept = i_req && o_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_req <= 1'b0;
    end else if (accept) begin
      o_req <= 1'b1;
    end else if (i_ack) begin
      o_req <= 1'b0;
    end
  end

  // Held stable until the consumer acknowledges.
  always_ff @(posedge clk) begin
    if (accept) begin
      o_data <= xlen_t'(i_rdata);
      o_rd   <= i_rd;
    end
  end

endmodule

// ==== src.f ====
source/lsu_pkg.sv
source/mem_unit.sv
source/exe_stage.sv
source/mem_stage.sv
source/wb_stage.sv
source/lsu_top.sv
tests/tb_lsu.sv

// ==== tests/tb_lsu.sv ====
// Load/store pipeline testbench
module tb_lsu;
  import lsu_pkg::*;

  localparam int MEM_WORDS     = 256;
  localparam int MEM_BYTES     = MEM_WORDS * 8;
  // Small region so loads often hit earlier stores.
  localparam int REGION_BYTES  = 128;
  localparam int ACK_TIMEOUT   = 200;
  localparam int DRAIN_TIMEOUT = 200;

  logic             clk = 1'b0;
  logic             rst;
  logic             i_req;
  logic             o_ack;
  insn_u            i_insn;
  xlen_t            i_rs1_val;
  xlen_t            i_rs2_val;
  logic             o_wb_req;
  logic             i_wb_ack;
  logic [REG_W-1:0] o_wb_rd;
  xlen_t            o_wb_data;

  int               seed;
  int               cyc;
  logic             fast_mode;
  logic             accepted;
  logic             next_ack;
  logic             held;
  xlen_t            held_data;
  logic [REG_W-1:0] held_rd;
  logic [7:0]       mem_model [MEM_BYTES];
  logic [REG_W-1:0] exp_rd [$];
  xlen_t            exp_data [$];
  int               exp_cyc [$];

  lsu_top #(
    .MEM_WORDS (MEM_WORDS)
  ) i_lsu_top (
    .clk       (clk),
    .rst       (rst),
    .i_req     (i_req),
    .o_ack     (o_ack),
    .i_insn    (i_insn),
    .i_rs1_val (i_rs1_val),
    .i_rs2_val (i_rs2_val),
    .o_wb_req  (o_wb_req),
    .i_wb_ack  (i_wb_ack),
    .o_wb_rd   (o_wb_rd),
    .o_wb_data (o_wb_data)
  );

  always #20 clk = ~clk;

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic stop_with_error(input string what);
    $display("Error at %0t: %s", $time, what);
    abort_run();
  endtask

  task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_rd(input string name, input logic [REG_W-1:0] got,
                          input logic [REG_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic int pick(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fffffff) % n;
  endfunction

  // Bytes from the model, extended as the funct3 code says.
  function automatic xlen_t load_value(input int addr, input funct3_t f3);
    xlen_t raw;
    int    nbytes;
    raw    = '0;
    nbytes = 1 << f3[1:0];
    for (int k = 0; k < nbytes; k++) begin
      raw[k*8 +: 8] = mem_model[addr + k];
    end
    if (!f3[2] && nbytes < 8 && raw[nbytes*8 - 1]) begin
      for (int b = nbytes * 8; b < XLEN; b++) begin
        raw[b] = 1'b1;
      end
    end
    return raw;
  endfunction

  function automatic xlen_t base_for(input int addr, input logic [11:0] imm);
    return xlen_t'(addr) - {{(XLEN-12){imm[11]}}, imm};
  endfunction

  // Writeback side, seen at the falling edge.
  task automatic watch_writeback();
    int r;
    if (held) begin
      check_flag("o_wb_req", o_wb_req, 1'b1);
      check_data("o_wb_data", o_wb_data, held_data);
      check_rd("o_wb_rd", o_wb_rd, held_rd);
    end
    if (o_wb_req && i_wb_ack) begin
      if (exp_data.size() == 0) begin
        stop_with_error("Writeback arrived with no load outstanding");
      end
      check_rd("o_wb_rd", o_wb_rd, exp_rd[0]);
      check_data("o_wb_data", o_wb_data, exp_data[0]);
      if (fast_mode) begin
        check_latency("load latency from issue", cyc - exp_cyc[0], 3);
      end
      void'(exp_rd.pop_front());
      void'(exp_data.pop_front());
      void'(exp_cyc.pop_front());
    end
    held      = o_wb_req && !i_wb_ack;
    held_data = o_wb_data;
    held_rd   = o_wb_rd;
    r         = $random(seed);
    next_ack  = fast_mode ? 1'b1 : r[0];
  endtask

  task automatic tick();
    @(negedge clk);
    if (fast_mode && i_req) begin
      check_flag("o_ack", o_ack, 1'b1);
    end
    accepted = i_req && o_ack;
    watch_writeback();
    @(posedge clk);
    cyc++;
    #1;
    i_wb_ack = next_ack;
  endtask

  task automatic send(input insn_u w, input xlen_t rs1, input xlen_t rs2, input bit is_ld,
                      input logic [REG_W-1:0] rd, input xlen_t value);
    int waited;
    waited    = 0;
    i_insn    = w;
    i_rs1_val = rs1;
    i_rs2_val = rs2;
    i_req     = 1'b1;
    accepted  = 1'b0;
    while (!accepted) begin
      if (waited == ACK_TIMEOUT) begin
        stop_with_error("Instruction was not accepted before the timeout");
      end
      tick();
      waited++;
    end
    i_req = 1'b0;
    if (is_ld) begin
      exp_rd.push_back(rd);
      exp_data.push_back(value);
      exp_cyc.push_back(cyc - 1);
    end
  endtask

  task automatic gen_item(input bit fast);
    insn_u            w;
    int               kind;
    int               size;
    int               addr;
    logic [11:0]      imm;
    funct3_t          f3;
    logic [REG_W-1:0] rd;
    xlen_t            rs2;
    if (!fast && pick(4) == 0) begin
      i_req = 1'b0;
      tick();
    end
    kind = fast ? pick(7) : pick(8);
    w    = '0;
    imm  = 12'(pick(4096));
    rs2  = {$random(seed), $random(seed)};
    if (kind < 3) begin
      f3   = funct3_t'(pick(4));
      size = 1 << f3;
      addr = pick(REGION_BYTES / size) * size;
      w.s.opcode = OPC_STORE;
      w.s.funct3 = f3;
      w.s.rs1    = REG_W'(pick(32));
      w.s.rs2    = REG_W'(pick(32));
      {w.s.imm_hi, w.s.imm_lo} = imm;
      // Model follows program order.
      for (int k = 0; k < size; k++) begin
        mem_model[addr + k] = rs2[k*8 +: 8];
      end
      send(w, base_for(addr, imm), rs2, 1'b0, '0, '0);
    end else if (kind < 7) begin
      f3   = funct3_t'(pick(7));
      size = 1 << f3[1:0];
      addr = pick(REGION_BYTES / size) * size;
      rd   = REG_W'(pick(32));
      w.i.opcode = OPC_LOAD;
      w.i.funct3 = f3;
      w.i.rs1    = REG_W'(pick(32));
      w.i.rd     = rd;
      w.i.imm    = imm;
      send(w, base_for(addr, imm), rs2, 1'b1, rd, load_value(addr, f3));
    end else begin
      w = $random(seed);
      if (w.i.opcode == OPC_LOAD || w.i.opcode == OPC_STORE) begin
        w.i.opcode[6] = ~w.i.opcode[6];
      end
      send(w, {$random(seed), $random(seed)}, rs2, 1'b0, '0, '0);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    i_req  = 1'b0;
    while (exp_data.size() != 0) begin
      if (waited == DRAIN_TIMEOUT) begin
        stop_with_error("Loads still outstanding when the drain timed out");
      end
      tick();
      waited++;
    end
  endtask

  initial begin
    seed      = 53;
    rst       = 1'b1;
    i_req     = 1'b0;
    i_insn    = '0;
    i_rs1_val = '0;
    i_rs2_val = '0;
    i_wb_ack  = 1'b0;
    fast_mode = 1'b0;
    accepted  = 1'b0;
    next_ack  = 1'b0;
    held      = 1'b0;
    held_data = '0;
    held_rd   = '0;
    cyc       = 0;
    for (int k = 0; k < MEM_BYTES; k++) begin
      mem_model[k] = 8'h00;
    end
    for (int c = 0; c < 8; c++) begin
      @(posedge clk);
      #1;
      check_flag("o_wb_req", o_wb_req, 1'b0);
      check_flag("o_ack", o_ack, 1'b1);
    end
    rst = 1'b0;
    @(negedge clk);
    check_flag("o_wb_req", o_wb_req, 1'b0);
    check_flag("o_ack", o_ack, 1'b1);
    @(posedge clk);
    #1;
    // Random mix with back-pressure.
    for (int n = 0; n < 300; n++) begin
      gen_item(1'b0);
    end
    drain();
    // Full rate, writeback always ready.
    fast_mode = 1'b1;
    tick();
    tick();
    for (int n = 0; n < 60; n++) begin
      gen_item(1'b1);
    end
    drain();
    repeat (4) tick();
    $display("Test OK");
    $finish;
  end

endmodule
